/* Makefile */
# Verilator build and run of the link testbench

VERILATOR ?= verilator
TOP       ?= tb_p2p_link
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build, run and search $(LOG) for the fail status"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
design/p2p_link_pkg.sv
design/link_bringup_timer.sv
design/marker_gearbox.sv
design/latency_line.sv
design/p2p_link_top.sv
sim/tb_clk_gen.sv
sim/p2p_link_sva.sv
sim/tb_p2p_link.sv

/* design/latency_line.sv */
// Fixed-latency delay line for packed link words
// Replays each strobed word a configured number of cycles later, with
// several words in flight at once

module latency_line
  import p2p_link_pkg::*;
(
  input  logic       m_wr_clk,
  input  logic       ns_adapter_rstn,
  input  logic [7:0] latency,
  input  phy_word_u  packed_word,
  input  logic       packed_valid,
  output phy_word_u  m2s_data_out,
  output logic       m2s_data_valid
);

  phy_word_u            word_mem [LAT_DEPTH];
  logic [LAT_DEPTH-1:0] vld_mem;
  logic [LAT_AW-1:0]    wr_ptr;
  logic [LAT_AW-1:0]    rd_ptr;
  logic [LAT_AW-1:0]    lat_sel;

  // Clamp to the legal range 1 to LAT_DEPTH-1
  always_comb
  begin
    if (latency == '0)
      lat_sel = LAT_AW'(1);
    else if (latency >= 8'(LAT_DEPTH))
      lat_sel = LAT_AW'(LAT_DEPTH - 1);
    else
      lat_sel = latency[LAT_AW-1:0];
  end

  // Entry written lat_sel cycles ago
  assign rd_ptr = wr_ptr - lat_sel;

  //////////////////////////////////////////////////
  // Circular memory
  //////////////////////////////////////////////////

  always_ff @(posedge m_wr_clk or negedge ns_adapter_rstn)
  begin
    if (!ns_adapter_rstn)
    begin
      wr_ptr  <= '0;
      vld_mem <= '0;
    end
    else
    begin
      wr_ptr          <= wr_ptr + 1'b1;
      vld_mem[wr_ptr] <= packed_valid;
    end
  end

  always_ff @(posedge m_wr_clk)
  begin
    word_mem[wr_ptr] <= packed_word;
  end

  // Output stage moves data only with a valid entry
  always_ff @(posedge m_wr_clk or negedge ns_adapter_rstn)
  begin
    if (!ns_adapter_rstn)
    begin
      m2s_data_valid <= 1'b0;
      m2s_data_out   <= '0;
    end
    else
    begin
      m2s_data_valid <= vld_mem[rd_ptr];
      if (vld_mem[rd_ptr])
        m2s_data_out <= word_mem[rd_ptr];
    end
  end

endmodule

/* design/link_bringup_timer.sv */
// Post-reset bring-up timer for the link
// Raises the four transfer enables once the DLL and flight times have passed

module link_bringup_timer
  import p2p_link_pkg::*;
(
  input  logic      m_wr_clk,
  input  logic      ns_adapter_rstn,
  input  link_cfg_t cfg,
  output xfer_en_t  xfer_en
);

  logic [CNT_W-1:0] ready_cnt;
  logic [CNT_W-1:0] master_lat_term;
  logic [CNT_W-1:0] slave_lat_term;
  logic [CNT_W-1:0] master_ms_thr;
  logic [CNT_W-1:0] slave_ms_thr;
  logic [CNT_W-1:0] slave_sl_thr;
  logic [CNT_W-1:0] master_sl_thr;

  // Saturating cycle count since reset release
  always_ff @(posedge m_wr_clk or negedge ns_adapter_rstn)
  begin
    if (!ns_adapter_rstn)
      ready_cnt <= '0;
    else if (ready_cnt != '1)
      ready_cnt <= ready_cnt + 1'b1;
  end

  //////////////////////////////////////////////////
  // Thresholds
  //////////////////////////////////////////////////

  always_comb
  begin
    // Master side always runs at full rate
    master_lat_term = CNT_W'(cfg.s2m_latency) * CNT_W'(RATE_FULL);
    slave_lat_term  = CNT_W'(cfg.m2s_latency) * CNT_W'(cfg.slave_rate);

    // Master RX ready after S2M flight and master DLL lock
    master_ms_thr = CNT_W'(cfg.master_dll_time) + master_lat_term;
    // Slave hears about it one M2S flight later
    slave_ms_thr  = master_ms_thr + slave_lat_term;

    // Slave RX ready after M2S flight and slave DLL lock
    slave_sl_thr  = CNT_W'(cfg.slave_dll_time) + slave_lat_term;
    // Master hears about it one S2M flight later
    master_sl_thr = slave_sl_thr + master_lat_term;
  end

  always_comb
  begin
    xfer_en.master_ms = (ready_cnt > master_ms_thr);
    xfer_en.slave_ms  = (ready_cnt > slave_ms_thr);
    xfer_en.slave_sl  = (ready_cnt > slave_sl_thr);
    xfer_en.master_sl = (ready_cnt > master_sl_thr);
  end

endmodule

/* design/marker_gearbox.sv */
// Full-rate master to slave gearbox
// Filters one lane per cycle and packs 1, 2 or 4 chunks into a wide word,
// aligned by a marker bit during the lock window and by a free phase after

module marker_gearbox
  import p2p_link_pkg::*;
(
  input  logic      m_wr_clk,
  input  logic      ns_adapter_rstn,
  input  link_cfg_t cfg,
  input  phy_word_u m2s_data_in,
  output phy_word_u packed_word,
  output logic      packed_valid,
  output logic      rate_error
);

  // Chunk holding register with the oldest chunk in entry 0
  typedef logic [MAX_RATIO-1:0][GEN2_LANE_W-1:0] chunk_arr_t;

  logic [GEN2_LANE_W-1:0] chunk_in;
  logic [GEN2_LANE_W-1:0] marker_shift;
  logic                   marker_hit;
  logic                   marker_take;
  logic                   rate_bad;
  logic [RATIO_W-1:0]     ratio;
  logic [PHASE_W-1:0]     last_phase;
  logic [PHASE_W-1:0]     phase;
  logic [PHASE_W-1:0]     phase_inc;
  logic [LOCK_CNT_W-1:0]  lock_cnt;
  logic                   lock_active;
  logic                   marker_seen;
  logic                   close_word;
  chunk_arr_t             chunks;
  chunk_arr_t             chunks_shr;
  chunk_arr_t             chunks_nxt;

  // Builds the wide word in the lane view of the current mode
  function automatic phy_word_u pack_word(input chunk_arr_t c,
                                          input logic [RATIO_W-1:0] n,
                                          input logic g2);
    phy_word_u w;
    w = '0;
    for (int i = 0; i < MAX_RATIO; i++)
    begin
      if (i < int'(n))
      begin
        if (g2)
          w.gen2_lanes[i] = c[i];
        else
          w.gen1_lanes[i] = c[i][GEN1_LANE_W-1:0];
      end
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Lane filter and rate decode
  //////////////////////////////////////////////////

  always_comb
  begin
    if (cfg.gen2)
      chunk_in = m2s_data_in.gen2_lanes[0];
    else
      chunk_in = GEN2_LANE_W'(m2s_data_in.gen1_lanes[0]);
  end

  always_comb
  begin
    case (cfg.slave_rate)
      RATE_FULL, RATE_HALF: rate_bad = 1'b0;
      RATE_QUARTER:         rate_bad = !cfg.gen2;
      default:              rate_bad = 1'b1;
    endcase
    // Symmetric mode forwards every chunk on its own
    if (cfg.asym)
      ratio = RATIO_W'(cfg.slave_rate);
    else
      ratio = RATIO_W'(RATE_FULL);
  end

  assign last_phase = PHASE_W'(ratio - 1'b1);
  assign phase_inc  = (phase == last_phase) ? '0 : phase + 1'b1;

  // Marker bit of the incoming chunk is zero beyond the lane width
  assign marker_shift = chunk_in >> cfg.marker_loc;
  assign marker_hit   = marker_shift[0];
  assign lock_active  = (lock_cnt != '0);
  assign marker_take  = cfg.asym && lock_active && marker_hit;

  //////////////////////////////////////////////////
  // Shift register and word close
  //////////////////////////////////////////////////

  assign chunks_shr = chunks >> GEN2_LANE_W;

  always_comb
  begin
    chunks_nxt = '0;
    for (int i = 0; i < MAX_RATIO; i++)
    begin
      if (i == int'(ratio) - 1)
        chunks_nxt[i] = chunk_in;
      else if (i < int'(ratio) - 1)
        chunks_nxt[i] = chunks_shr[i];
    end
  end

  always_comb
  begin
    if (!cfg.asym)
      close_word = 1'b1;
    else if (lock_active)
      close_word = marker_hit;
    else
      close_word = (phase == last_phase);
  end

  always_ff @(posedge m_wr_clk or negedge ns_adapter_rstn)
  begin
    if (!ns_adapter_rstn)
    begin
      chunks       <= '0;
      phase        <= '0;
      lock_cnt     <= LOCK_CNT_W'(LOCK_WINDOW);
      marker_seen  <= 1'b0;
      packed_valid <= 1'b0;
      rate_error   <= 1'b0;
    end
    else
    begin
      chunks       <= chunks_nxt;
      rate_error   <= rate_bad;
      packed_valid <= close_word && !rate_bad;
      // A marker inside the window realigns the phase
      if (marker_take)
      begin
        marker_seen <= 1'b1;
        phase       <= '0;
      end
      else
        phase <= phase_inc;
      if (marker_seen && lock_active)
        lock_cnt <= lock_cnt - 1'b1;
    end
  end

  always_ff @(posedge m_wr_clk)
  begin
    if (close_word)
      packed_word <= pack_word(chunks_nxt, ratio, cfg.gen2);
  end

endmodule

/* design/p2p_link_pkg.sv */
// Shared widths, rate codes and types for the master-to-slave link model
// Imported by every RTL module of the link

package p2p_link_pkg;

  //////////////////////////////////////////////////
  // Widths and limits
  //////////////////////////////////////////////////

  localparam int PHY_W       = 320;
  localparam int GEN2_LANE_W = 80;
  localparam int GEN1_LANE_W = 40;
  localparam int MAX_RATIO   = 4;
  localparam int LOCK_WINDOW = 15;
  localparam int LAT_DEPTH   = 16;
  localparam int CNT_W       = 16;

  // Derived widths
  localparam int LAT_AW      = $clog2(LAT_DEPTH);
  localparam int LOCK_CNT_W  = $clog2(LOCK_WINDOW + 1);
  localparam int PHASE_W     = $clog2(MAX_RATIO);
  localparam int RATIO_W     = $clog2(MAX_RATIO + 1);

  // Lane counts per PHY word
  localparam int GEN2_LANES  = PHY_W / GEN2_LANE_W;
  localparam int GEN1_LANES  = PHY_W / GEN1_LANE_W;

  //////////////////////////////////////////////////
  // Rate codes
  //////////////////////////////////////////////////

  typedef logic [3:0] rate_t;

  // Code value equals chunks per packed word
  localparam rate_t RATE_FULL    = 4'd1;
  localparam rate_t RATE_HALF    = 4'd2;
  localparam rate_t RATE_QUARTER = 4'd4;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Static link configuration
  typedef struct packed {
    logic       gen2;
    logic       asym;
    rate_t      slave_rate;
    logic [7:0] marker_loc;
    logic [7:0] m2s_latency;
    logic [7:0] s2m_latency;
    logic [7:0] master_dll_time;
    logic [7:0] slave_dll_time;
  } link_cfg_t;

  // Transfer enables for both ends of the link
  typedef struct packed {
    logic master_sl;
    logic master_ms;
    logic slave_sl;
    logic slave_ms;
  } xfer_en_t;

  // One PHY word, decoded as Gen2 or Gen1 lanes
  typedef union packed {
    logic [GEN2_LANES-1:0][GEN2_LANE_W-1:0] gen2_lanes;
    logic [GEN1_LANES-1:0][GEN1_LANE_W-1:0] gen1_lanes;
  } phy_word_u;

endpackage

/* design/p2p_link_top.sv */
// Top level of the master-to-slave link model
// Bring-up timer, marker gearbox and latency line on m_wr_clk

module p2p_link_top
  import p2p_link_pkg::*;
(
  input  logic      m_wr_clk,
  input  logic      ns_adapter_rstn,
  input  link_cfg_t cfg,
  input  phy_word_u m2s_data_in,
  output xfer_en_t  xfer_en,
  output phy_word_u m2s_data_out,
  output logic      m2s_data_valid,
  output logic      rate_error
);

  // Gearbox to latency line
  phy_word_u packed_word;
  logic      packed_valid;

  link_bringup_timer u_bringup_timer (
    .m_wr_clk        (m_wr_clk),
    .ns_adapter_rstn (ns_adapter_rstn),
    .cfg             (cfg),
    .xfer_en         (xfer_en)
  );

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  marker_gearbox u_marker_gearbox (
    .m_wr_clk        (m_wr_clk),
    .ns_adapter_rstn (ns_adapter_rstn),
    .cfg             (cfg),
    .m2s_data_in     (m2s_data_in),
    .packed_word     (packed_word),
    .packed_valid    (packed_valid),
    .rate_error      (rate_error)
  );

  latency_line u_latency_line (
    .m_wr_clk        (m_wr_clk),
    .ns_adapter_rstn (ns_adapter_rstn),
    .latency         (cfg.m2s_latency),
    .packed_word     (packed_word),
    .packed_valid    (packed_valid),
    .m2s_data_out    (m2s_data_out),
    .m2s_data_valid  (m2s_data_valid)
  );

endmodule

/* sim/p2p_link_sva.sv */
// Concurrent checks on the outputs of the link top level
// Bound to p2p_link_top at the end of this file

module p2p_link_sva
  import p2p_link_pkg::*;
(
  input logic      m_wr_clk,
  input logic      ns_adapter_rstn,
  input xfer_en_t  xfer_en,
  input phy_word_u m2s_data_out,
  input logic      m2s_data_valid,
  input logic      rate_error
);

  // All outputs sit at their reset values while reset is held
  outputs_low_in_reset: assert property (@(posedge m_wr_clk)
    !ns_adapter_rstn |-> (!m2s_data_valid && xfer_en == '0 && !rate_error
                          && m2s_data_out == '0))
    else $error("outputs not at reset values during reset");

  // Enables are sticky until the next reset
  enables_never_fall: assert property (@(posedge m_wr_clk) disable iff (!ns_adapter_rstn)
    !($fell(xfer_en.master_sl) || $fell(xfer_en.master_ms)
      || $fell(xfer_en.slave_sl) || $fell(xfer_en.slave_ms)))
    else $error("transfer enable dropped after rising");

  no_strobe_on_rate_error: assert property (@(posedge m_wr_clk) disable iff (!ns_adapter_rstn)
    rate_error |-> !m2s_data_valid)
    else $error("data strobe while rate_error is high");

endmodule

bind p2p_link_top p2p_link_sva u_link_sva (
  .m_wr_clk        (m_wr_clk),
  .ns_adapter_rstn (ns_adapter_rstn),
  .xfer_en         (xfer_en),
  .m2s_data_out    (m2s_data_out),
  .m2s_data_valid  (m2s_data_valid),
  .rate_error      (rate_error)
);

/* sim/tb_clk_gen.sv */
// Free-running clock for the link testbench
// Period of 8 time units, starting low

module tb_clk_gen
(
  output logic m_wr_clk
);

  initial
  begin
    m_wr_clk = 1'b0;
    forever
      #4 m_wr_clk = ~m_wr_clk;
  end

endmodule

/* sim/tb_p2p_link.sv */
// Testbench for the master-to-slave link model
// Runs bring-up, symmetric and packed traffic and checks every strobe
// against a reference model built from the gearbox and latency rules

module tb_p2p_link
  import p2p_link_pkg::*;
();

  typedef logic [MAX_RATIO-1:0][GEN2_LANE_W-1:0] chunk_hist_t;

  typedef struct packed {
    int               due;
    logic [PHY_W-1:0] word;
  } exp_entry_t;

  logic      m_wr_clk;
  logic      ns_adapter_rstn;
  link_cfg_t cfg;
  phy_word_u m2s_data_in;
  xfer_en_t  xfer_en;
  phy_word_u m2s_data_out;
  logic      m2s_data_valid;
  logic      rate_error;

  // Reference model state with the newest chunk in hist entry 0
  exp_entry_t  exp_q[$];
  chunk_hist_t hist;
  int          cyc = 0;
  int          phase = 0;
  int          lock_left = LOCK_WINDOW;
  bit          marker_seen = 1'b0;
  bit          rate_bad_exp = 1'b0;

  int          rd_idx = 0;
  int          data_errs = 0;
  int          strobe_errs = 0;
  int          level_errs = 0;
  int          timeout_errs = 0;
  int          drain_mark = 0;
  logic [31:0] lfsr;
  string       test_name;

  tb_clk_gen u_clk_gen (.m_wr_clk(m_wr_clk));

  p2p_link_top DUT (
    .m_wr_clk        (m_wr_clk),
    .ns_adapter_rstn (ns_adapter_rstn),
    .cfg             (cfg),
    .m2s_data_in     (m2s_data_in),
    .xfer_en         (xfer_en),
    .m2s_data_out    (m2s_data_out),
    .m2s_data_valid  (m2s_data_valid),
    .rate_error      (rate_error)
  );

  //////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [GEN2_LANE_W-1:0] random_lane();
    logic [GEN2_LANE_W-1:0] v;
    v = '0;
    for (int i = 0; i < GEN2_LANE_W; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // Oldest chunk of the group lands in lane 0
  function automatic logic [PHY_W-1:0] expected_word(input bit gen2, input int ratio,
                                                     input chunk_hist_t c);
    logic [PHY_W-1:0] w;
    w = '0;
    for (int i = 0; i < ratio; i++)
    begin
      if (gen2)
        w[i*GEN2_LANE_W +: GEN2_LANE_W] = c[ratio-1-i];
      else
        w[i*GEN1_LANE_W +: GEN1_LANE_W] = c[ratio-1-i][GEN1_LANE_W-1:0];
    end
    return w;
  endfunction

  function automatic xfer_en_t expected_enables(input link_cfg_t c, input int count);
    int       m2s_term;
    int       ms_thr;
    int       sl_thr;
    xfer_en_t e;
    m2s_term    = int'(c.m2s_latency) * int'(c.slave_rate);
    ms_thr      = int'(c.master_dll_time) + int'(c.s2m_latency);
    sl_thr      = int'(c.slave_dll_time) + m2s_term;
    e.master_ms = count > ms_thr;
    e.slave_ms  = count > ms_thr + m2s_term;
    e.slave_sl  = count > sl_thr;
    e.master_sl = count > sl_thr + int'(c.s2m_latency);
    return e;
  endfunction

  function automatic link_cfg_t make_cfg(input bit gen2, input bit asym, input rate_t rate,
                                         input int latency);
    link_cfg_t c;
    c.gen2            = gen2;
    c.asym            = asym;
    c.slave_rate      = rate;
    c.marker_loc      = 8'd5;
    c.m2s_latency     = 8'(latency);
    c.s2m_latency     = 8'd5;
    c.master_dll_time = 8'd20;
    c.slave_dll_time  = 8'd10;
    return c;
  endfunction

  //////////////////////////////////////////////////
  // Reference model steps once per captured chunk
  //////////////////////////////////////////////////

  always @(posedge m_wr_clk or negedge ns_adapter_rstn)
  begin
    logic [GEN2_LANE_W-1:0] chunk;
    logic [GEN2_LANE_W-1:0] marker_bits;
    int                     ratio;
    bit                     close;
    bit                     bad;
    bit                     take;
    exp_entry_t             e;
    if (!ns_adapter_rstn)
    begin
      cyc          = 0;
      phase        = 0;
      lock_left    = LOCK_WINDOW;
      marker_seen  = 1'b0;
      rate_bad_exp = 1'b0;
      hist         = '0;
    end
    else
    begin
      cyc   = cyc + 1;
      chunk = cfg.gen2 ? m2s_data_in.gen2_lanes[0]
                       : GEN2_LANE_W'(m2s_data_in.gen1_lanes[0]);
      hist  = {hist[MAX_RATIO-2:0], chunk};
      ratio = cfg.asym ? int'(cfg.slave_rate) : 1;
      bad   = !(cfg.slave_rate == RATE_FULL || cfg.slave_rate == RATE_HALF
                || (cfg.slave_rate == RATE_QUARTER && cfg.gen2));
      marker_bits = chunk >> cfg.marker_loc;
      if (!cfg.asym)
        close = 1'b1;
      else if (lock_left > 0)
        close = marker_bits[0];
      else
        close = (phase == ratio - 1);
      if (close && !bad)
      begin
        e.due  = cyc + 1 + int'(cfg.m2s_latency);
        e.word = expected_word(cfg.gen2, ratio, hist);
        exp_q.push_back(e);
      end
      // Markers resync the phase only inside the lock window
      take = cfg.asym && lock_left > 0 && marker_bits[0];
      if (marker_seen && lock_left > 0)
        lock_left = lock_left - 1;
      if (take)
      begin
        marker_seen = 1'b1;
        phase       = 0;
      end
      else
        phase = (phase >= ratio - 1) ? 0 : phase + 1;
      rate_bad_exp = bad;
    end
  end

  // Outputs are compared mid-cycle where they are stable
  always @(negedge m_wr_clk)
  begin
    if (!ns_adapter_rstn)
      rd_idx = exp_q.size();
    else
    begin
      assert (xfer_en == expected_enables(cfg, cyc))
      else
      begin
        $display("Fail %s: xfer_en expected %b actual %b", test_name,
                 expected_enables(cfg, cyc), xfer_en);
        level_errs++;
      end
      assert (rate_error == rate_bad_exp)
      else
      begin
        $display("Fail %s: rate_error expected %b actual %b", test_name,
                 rate_bad_exp, rate_error);
        level_errs++;
      end
      if (rd_idx < exp_q.size() && exp_q[rd_idx].due == cyc)
      begin
        assert (m2s_data_valid)
        else
        begin
          $display("Missing data strobe in %s at cycle %0d", test_name, cyc);
          strobe_errs++;
        end
        if (m2s_data_valid)
          assert (m2s_data_out == exp_q[rd_idx].word)
          else
          begin
            $display("Fail %s: data expected %h actual %h", test_name,
                     exp_q[rd_idx].word, m2s_data_out);
            data_errs++;
          end
        rd_idx++;
      end
      else
        assert (!m2s_data_valid)
        else
        begin
          $display("Unexpected data strobe in %s at cycle %0d", test_name, cyc);
          strobe_errs++;
        end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic next_edge();
    @(posedge m_wr_clk);
    #1;
  endtask

  task automatic apply_reset(input link_cfg_t c);
    next_edge();
    ns_adapter_rstn = 1'b0;
    cfg             = c;
    m2s_data_in     = '0;
    repeat (8)
      next_edge();
    ns_adapter_rstn = 1'b1;
  endtask

  // Marker goes on the last chunk of each group while upper lanes carry junk
  task automatic send_chunks(input int n, input int ratio);
    phy_word_u              w;
    logic [GEN2_LANE_W-1:0] lane0;
    int                     last;
    last = 0;
    for (int k = 0; k < n; k++)
    begin
      next_edge();
      lane0 = random_lane() & ~(GEN2_LANE_W'(1) << cfg.marker_loc);
      if (k % ratio == ratio - 1)
        lane0 = lane0 | (GEN2_LANE_W'(1) << cfg.marker_loc);
      w               = '0;
      w.gen2_lanes[0] = lane0;
      w.gen2_lanes[1] = random_lane();
      m2s_data_in     = w;
      last            = cyc + 1;
    end
    next_edge();
    m2s_data_in = '0;
    drain_mark  = last + 1 + int'(cfg.m2s_latency);
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    while (cyc <= drain_mark && guard < 100)
    begin
      @(negedge m_wr_clk);
      guard++;
    end
    assert (cyc > drain_mark)
    else
    begin
      $display("Timed out waiting for the last word of %s", test_name);
      timeout_errs++;
    end
  endtask

  task automatic wait_enables();
    int guard;
    guard = 0;
    while (xfer_en != 4'hf && guard < 200)
    begin
      @(negedge m_wr_clk);
      guard++;
    end
    assert (xfer_en == 4'hf)
    else
    begin
      $display("Timed out waiting for all transfer enables");
      timeout_errs++;
    end
  endtask

  task automatic wait_rate_error();
    int guard;
    guard = 0;
    while (!rate_error && guard < 20)
    begin
      @(negedge m_wr_clk);
      guard++;
    end
    assert (rate_error)
    else
    begin
      $display("Timed out waiting for rate_error to rise");
      timeout_errs++;
    end
  endtask

  initial
  begin
    ns_adapter_rstn = 1'b0;
    cfg             = '0;
    m2s_data_in     = '0;
    lfsr            = 32'hea4f;
    test_name       = "reset";

    // Bring-up and then symmetric traffic with several words in flight
    apply_reset(make_cfg(1'b1, 1'b0, RATE_HALF, 6));
    test_name = "bringup";
    wait_enables();
    test_name = "sym_gen2";
    send_chunks(40, 1);
    wait_drain();

    // Markers run on well past the lock window
    apply_reset(make_cfg(1'b1, 1'b1, RATE_HALF, 3));
    test_name = "gen2_half";
    send_chunks(48, 2);
    wait_drain();

    apply_reset(make_cfg(1'b1, 1'b1, RATE_QUARTER, 1));
    test_name = "gen2_quarter";
    send_chunks(64, 4);
    wait_drain();

    apply_reset(make_cfg(1'b0, 1'b1, RATE_HALF, 4));
    test_name = "gen1_half";
    send_chunks(32, 2);
    wait_drain();

    apply_reset(make_cfg(1'b0, 1'b1, RATE_QUARTER, 2));
    test_name = "gen1_quarter";
    wait_rate_error();
    send_chunks(16, 4);
    wait_drain();

    $display("Errors: data %0d, strobe %0d, level %0d, timeout %0d",
             data_errs, strobe_errs, level_errs, timeout_errs);
    if (data_errs + strobe_errs + level_errs + timeout_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
